// ==== Bender.yml ====
package:
  name: bp_top

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bp_pkg.sv
      - hdl/bram_2rport_1wport.sv
      - hdl/ghr.sv
      - hdl/pht.sv
      - hdl/bp_ctrl.sv
      - hdl/bp_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/bp_tb.sv

// ==== bp_top.f ====
+incdir+hdl
hdl/bp_pkg.sv
hdl/bram_2rport_1wport.sv
hdl/ghr.sv
hdl/pht.sv
hdl/bp_ctrl.sv
hdl/bp_top.sv
dv/bp_tb.sv

// ==== dv/bp_tb.sv ====
// directed testbench for the branch direction predictor
// a reference table and history predict every response

`timescale 1ns/1ps
`default_nettype none

`include "bp_macros.svh"

module bp_tb;

    localparam int TIMEOUT = 50;

    logic               CLK;
    logic               nRST;
    bp_pkg::asid_t      arch_asid;
    logic               pred_req_valid;
    bp_pkg::pred_req_t  pred_req;
    logic               pred_req_ready;
    logic               pred_resp_valid;
    bp_pkg::pred_resp_t pred_resp;
    logic               pred_resp_ready;
    logic               update_valid;
    bp_pkg::update_t    update;

    // reference model
    bp_pkg::pht_set_t   model_table [1 << `BP_LOG_PHT_SETS];
    bp_pkg::gh_t        model_gh;
    bp_pkg::asid_t      cur_asid;

    bp_top UUT (
        .CLK             (CLK),
        .nRST            (nRST),
        .arch_asid       (arch_asid),
        .pred_req_valid  (pred_req_valid),
        .pred_req        (pred_req),
        .pred_req_ready  (pred_req_ready),
        .pred_resp_valid (pred_resp_valid),
        .pred_resp       (pred_resp),
        .pred_resp_ready (pred_resp_ready),
        .update_valid    (update_valid),
        .update          (update)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // compares

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input bp_pkg::pred_resp_t got,
                              input bp_pkg::pred_resp_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_gh(input string name, input bp_pkg::gh_t got, input bp_pkg::gh_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    // ------------------------------------------------------------
    // reference model

    // asid reversed into the index, asid bit 0 lands on the index msb
    function automatic bp_pkg::pht_idx_t model_index(bp_pkg::fetch_idx_t idx, bp_pkg::gh_t g,
                                                     bp_pkg::asid_t a);
        bp_pkg::pht_idx_t asid_rev;
        for (int i = 0; i < 8; i++) begin
            asid_rev[7-i] = a[i];
        end
        return idx ^ g[10:3] ^ asid_rev;
    endfunction

    function automatic logic [1:0] model_counter(logic [1:0] ctr, logic taken);
        if (taken) begin
            return (ctr == 2'b01) ? 2'b00 : 2'b11;
        end
        return (ctr == 2'b11) ? 2'b10 : 2'b01;
    endfunction

    function automatic bp_pkg::gh_t gh_after(bp_pkg::gh_t g, logic taken);
        return {g[`BP_GH_LENGTH-2:0], taken};
    endfunction

    task automatic model_update(input bp_pkg::update_t u);
        bp_pkg::pht_idx_t    idx;
        bp_pkg::fetch_lane_t ln;
        idx = model_index(u.pc.fields.fetch_idx, u.gh, cur_asid);
        ln  = u.pc.fields.lane ^ u.gh[2:0];
        model_table[idx][ln] = model_counter(model_table[idx][ln], u.taken);
        model_gh = gh_after(model_gh, u.taken);
    endtask

    function automatic bp_pkg::pred_resp_t model_predict(bp_pkg::pred_req_t r);
        bp_pkg::pht_idx_t    idx;
        bp_pkg::fetch_lane_t ln;
        bp_pkg::pred_resp_t  p;
        idx     = model_index(r.pc.fields.fetch_idx, model_gh, cur_asid);
        ln      = r.redirect_lane ^ model_gh[2:0];
        p.taken = model_table[idx][ln][1];
        p.gh    = model_gh;
        return p;
    endfunction

    // ------------------------------------------------------------
    // stimulus

    function automatic bp_pkg::pc38_u rand_pc();
        logic [63:0]   r;
        bp_pkg::pc38_u pc;
        r      = {$urandom(), $urandom()};
        pc.raw = r[37:0];
        return pc;
    endfunction

    function automatic bp_pkg::pc38_u with_lane(bp_pkg::pc38_u pc, bp_pkg::fetch_lane_t lane);
        pc.fields.lane = lane;
        return pc;
    endfunction

    // redirect lane from the pc, fetch pc lane bits set apart from it
    function automatic bp_pkg::pred_req_t make_req(bp_pkg::pc38_u pc);
        bp_pkg::pred_req_t r;
        r.pc            = with_lane(pc, ~pc.fields.lane);
        r.redirect_lane = pc.fields.lane;
        return r;
    endfunction

    function automatic bp_pkg::update_t make_update(bp_pkg::pc38_u pc, bp_pkg::gh_t g,
                                                    logic taken);
        bp_pkg::update_t u;
        u.pc    = pc;
        u.gh    = g;
        u.taken = taken;
        return u;
    endfunction

    task automatic wait_req_ready();
        int n;
        n = 0;
        @(negedge CLK);
        while (pred_req_ready !== 1'b1) begin
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for pred_req_ready");
            @(negedge CLK);
        end
    endtask

    task automatic wait_resp_valid(input logic level);
        int n;
        n = 0;
        @(negedge CLK);
        while (pred_resp_valid !== level) begin
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for pred_resp_valid to change");
            @(negedge CLK);
        end
    endtask

    task automatic set_asid(input bp_pkg::asid_t a);
        @(posedge CLK);
        arch_asid <= a;
        cur_asid = a;
    endtask

    task automatic send_update(input bp_pkg::update_t u);
        @(posedge CLK);
        update_valid <= 1'b1;
        update       <= u;
        @(posedge CLK);
        update_valid <= 1'b0;
        model_update(u);
    endtask

    // consecutive edges, the second update reads the forwarded set
    task automatic send_update_pair(input bp_pkg::update_t u1, input bp_pkg::update_t u2);
        @(posedge CLK);
        update_valid <= 1'b1;
        update       <= u1;
        @(posedge CLK);
        update       <= u2;
        @(posedge CLK);
        update_valid <= 1'b0;
        model_update(u1);
        model_update(u2);
    endtask

    task automatic send_req(input bp_pkg::pred_req_t r);
        @(posedge CLK);
        pred_req_valid <= 1'b1;
        pred_req       <= r;
        wait_req_ready();
        @(posedge CLK);
        pred_req_valid <= 1'b0;
    endtask

    task automatic recv_resp(output bp_pkg::pred_resp_t got);
        wait_resp_valid(1'b1);
        got = pred_resp;
        @(posedge CLK);
    endtask

    task automatic predict_check(input bp_pkg::pc38_u pc, output bp_pkg::pred_resp_t got);
        bp_pkg::pred_req_t  r;
        bp_pkg::pred_resp_t exp;
        r   = make_req(pc);
        exp = model_predict(r);
        send_req(r);
        recv_resp(got);
        check_resp("pred_resp", got, exp);
    endtask

    // ------------------------------------------------------------
    // tests

    task automatic test_reset_state();
        bp_pkg::pred_resp_t got;
        @(negedge CLK);
        check_bit("pred_req_ready", pred_req_ready, 1'b1);
        check_bit("pred_resp_valid", pred_resp_valid, 1'b0);
        predict_check(rand_pc(), got);
        check_bit("pred_resp.taken", got.taken, 1'b0);
        check_gh("pred_resp.gh", got.gh, '0);
    endtask

    task automatic test_training();
        bp_pkg::pc38_u      pc;
        bp_pkg::pc38_u      pc2;
        bp_pkg::gh_t        g;
        bp_pkg::gh_t        g2;
        bp_pkg::pred_resp_t got;
        pc = rand_pc();
        g  = gh_after(model_gh, 1'b1);
        send_update(make_update(pc, g, 1'b1));
        predict_check(pc, got);
        check_bit("pred_resp.taken", got.taken, 1'b1);
        // pc2 reaches the same counter under the history two more updates leave
        g2  = gh_after(gh_after(model_gh, 1'b0), 1'b0);
        pc2 = pc;
        pc2.fields.fetch_idx = pc.fields.fetch_idx ^ g[10:3] ^ g2[10:3];
        pc2.fields.lane      = pc.fields.lane ^ g[2:0] ^ g2[2:0];
        // strong taken to weak taken to strong not-taken
        send_update(make_update(pc2, g2, 1'b0));
        send_update(make_update(pc2, g2, 1'b0));
        predict_check(pc2, got);
        check_bit("pred_resp.taken", got.taken, 1'b0);
    endtask

    task automatic test_history_lanes();
        logic [31:0]        rv;
        bp_pkg::pc38_u      pc;
        bp_pkg::gh_t        g;
        bp_pkg::pred_resp_t got;
        for (int i = 0; i < 6; i++) begin
            rv = $urandom();
            send_update(make_update(rand_pc(), rv[10:0], rv[16]));
        end
        predict_check(rand_pc(), got);
        check_gh("pred_resp.gh", got.gh, model_gh);
        // two lanes of one set trained in opposite directions
        pc = rand_pc();
        g  = gh_after(gh_after(model_gh, 1'b1), 1'b0);
        send_update(make_update(pc, g, 1'b1));
        send_update(make_update(with_lane(pc, pc.fields.lane ^ 3'h5), g, 1'b0));
        predict_check(pc, got);
        predict_check(with_lane(pc, pc.fields.lane ^ 3'h5), got);
        predict_check(with_lane(pc, pc.fields.lane ^ 3'h2), got);
    endtask

    task automatic test_forwarding();
        bp_pkg::pc38_u      pc;
        bp_pkg::gh_t        g;
        bp_pkg::pred_resp_t got;
        pc = rand_pc();
        g  = gh_after(gh_after(model_gh, 1'b1), 1'b1);
        send_update_pair(make_update(pc, g, 1'b1),
                         make_update(with_lane(pc, pc.fields.lane ^ 3'h1), g, 1'b1));
        predict_check(pc, got);
        predict_check(with_lane(pc, pc.fields.lane ^ 3'h1), got);
    endtask

    task automatic test_backpressure();
        bp_pkg::pc38_u      pc;
        bp_pkg::pred_req_t  r;
        bp_pkg::pred_resp_t exp;
        bp_pkg::pred_resp_t held;
        @(posedge CLK);
        pred_resp_ready <= 1'b0;
        pc  = rand_pc();
        r   = make_req(pc);
        exp = model_predict(r);
        send_req(r);
        wait_resp_valid(1'b1);
        held = pred_resp;
        check_resp("pred_resp", held, exp);
        check_bit("pred_req_ready", pred_req_ready, 1'b0);
        // retrain the very counter behind the held response
        send_update(make_update(pc, exp.gh, ~exp.taken));
        for (int i = 0; i < 4; i++) begin
            @(negedge CLK);
            check_bit("pred_resp_valid", pred_resp_valid, 1'b1);
            check_bit("pred_req_ready", pred_req_ready, 1'b0);
            check_resp("pred_resp", pred_resp, held);
        end
        @(posedge CLK);
        pred_resp_ready <= 1'b1;
        wait_resp_valid(1'b0);
    endtask

    task automatic test_asid();
        bp_pkg::pc38_u      pc;
        bp_pkg::gh_t        g;
        bp_pkg::pred_resp_t got;
        set_asid(9'h005);
        pc = rand_pc();
        g  = gh_after(model_gh, 1'b1);
        send_update(make_update(pc, g, 1'b1));
        predict_check(pc, got);
        set_asid(9'h0a0);
        predict_check(pc, got);
        set_asid(9'h000);
    endtask

    // ------------------------------------------------------------
    // main sequence

    initial begin
        void'($urandom(88922));
        nRST            = 1'b0;
        arch_asid       = '0;
        pred_req_valid  = 1'b0;
        pred_req        = '0;
        pred_resp_ready = 1'b1;
        update_valid    = 1'b0;
        update          = '0;
        cur_asid        = '0;
        model_gh        = '0;
        for (int i = 0; i < (1 << `BP_LOG_PHT_SETS); i++) begin
            model_table[i] = '0;
        end
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        test_reset_state();
        test_training();
        test_history_lanes();
        test_forwarding();
        test_backpressure();
        test_asid();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/bp_ctrl.sv ====
// prediction control
// accepts requests, tracks the table read and holds one response slot

`timescale 1ns/1ps
`default_nettype none

module bp_ctrl (
    input  logic                CLK,
    input  logic                nRST,
    input  bp_pkg::gh_t         gh,

    input  logic                pred_req_valid,
    input  bp_pkg::pred_req_t   pred_req,
    output logic                pred_req_ready,

    output logic                pred_resp_valid,
    output bp_pkg::pred_resp_t  pred_resp,
    input  logic                pred_resp_ready,

    output logic                rd_valid,
    output bp_pkg::pc38_u       rd_pc,
    output bp_pkg::fetch_lane_t rd_lane,
    input  logic                rd_taken
);

    logic                slot_free;
    logic                rd_pending;
    bp_pkg::fetch_lane_t pend_lane;
    bp_pkg::gh_t         pend_gh;

    // slot empty, or its response leaves on this edge
    assign slot_free      = !pred_resp_valid | pred_resp_ready;
    assign pred_req_ready = slot_free;

    // table read only on acceptance, so RAM output holds otherwise
    assign rd_valid = pred_req_valid & slot_free;
    assign rd_pc    = pred_req.pc;
    assign rd_lane  = pend_lane;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_pending      <= 1'b0;
            pred_resp_valid <= 1'b0;
        end else if (slot_free) begin
            rd_pending      <= rd_valid;
            pred_resp_valid <= rd_pending;
        end
    end

    // payload of the read in flight and of the held response
    always_ff @(posedge CLK) begin
        if (rd_valid) begin
            pend_lane <= pred_req.redirect_lane;
            pend_gh   <= gh;
        end
        if (slot_free && rd_pending) begin
            pred_resp <= '{taken: rd_taken, gh: pend_gh};
        end
    end

    // ----------------------------------------------------------
    // held response must not move under back-pressure
    a_resp_hold : assert property (
        @(posedge CLK) disable iff (!nRST)
        pred_resp_valid && !pred_resp_ready |=> pred_resp_valid && $stable(pred_resp)
    );

endmodule

`default_nettype wire

// ==== hdl/bp_macros.svh ====
// branch predictor sizing
// table depth, lanes per fetch block, history and ASID widths

`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// log2 of pattern history table sets
`define BP_LOG_PHT_SETS 8

// log2 of lanes in one fetch block
`define BP_LOG_FETCH_LANES 3

// global history length, index bits plus lane bits
`define BP_GH_LENGTH 11

// address space id width
`define BP_ASID_WIDTH 9

`endif

// ==== hdl/bp_pkg.sv ====
// branch predictor package
// shared types for the fetch PC, table sets and the predict/update interfaces

`default_nettype none

`include "bp_macros.svh"

package bp_pkg;

    typedef logic [`BP_ASID_WIDTH-1:0]      asid_t;
    typedef logic [`BP_LOG_PHT_SETS-1:0]    fetch_idx_t;
    typedef logic [`BP_LOG_FETCH_LANES-1:0] fetch_lane_t;
    typedef logic [`BP_LOG_PHT_SETS-1:0]    pht_idx_t;
    typedef logic [`BP_GH_LENGTH-1:0]       gh_t;

    // one two-bit counter per lane, {taken, strong}
    typedef logic [(1 << `BP_LOG_FETCH_LANES)-1:0][1:0] pht_set_t;

    // fetch pc, either as a plain word or split into fields
    typedef union packed {
        logic [37:0] raw;
        struct packed {
            logic [26:0] tag;
            fetch_idx_t  fetch_idx;
            fetch_lane_t lane;
        } fields;
    } pc38_u;

    typedef struct packed {
        pc38_u       pc;
        fetch_lane_t redirect_lane;
    } pred_req_t;

    typedef struct packed {
        logic taken;
        gh_t  gh;
    } pred_resp_t;

    typedef struct packed {
        pc38_u pc;
        gh_t   gh;
        logic  taken;
    } update_t;

endpackage

`default_nettype wire

// ==== hdl/bp_top.sv ====
// branch direction predictor top level
// control, global history and pattern history table

`timescale 1ns/1ps
`default_nettype none

module bp_top (
    input  logic               CLK,
    input  logic               nRST,
    input  bp_pkg::asid_t      arch_asid,

    input  logic               pred_req_valid,
    input  bp_pkg::pred_req_t  pred_req,
    output logic               pred_req_ready,

    output logic               pred_resp_valid,
    output bp_pkg::pred_resp_t pred_resp,
    input  logic               pred_resp_ready,

    input  logic               update_valid,
    input  bp_pkg::update_t    update
);

    bp_pkg::gh_t         gh;
    logic                rd_valid;
    bp_pkg::pc38_u       rd_pc;
    bp_pkg::fetch_lane_t rd_lane;
    logic                rd_taken;

    bp_ctrl ctrl (
        .CLK             (CLK),
        .nRST            (nRST),
        .gh              (gh),
        .pred_req_valid  (pred_req_valid),
        .pred_req        (pred_req),
        .pred_req_ready  (pred_req_ready),
        .pred_resp_valid (pred_resp_valid),
        .pred_resp       (pred_resp),
        .pred_resp_ready (pred_resp_ready),
        .rd_valid        (rd_valid),
        .rd_pc           (rd_pc),
        .rd_lane         (rd_lane),
        .rd_taken        (rd_taken)
    );

    ghr history (
        .CLK          (CLK),
        .nRST         (nRST),
        .update_valid (update_valid),
        .update_taken (update.taken),
        .gh           (gh)
    );

    pht pattern_table (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .arch_asid               (arch_asid),
        .read_req_valid          (rd_valid),
        .read_req_pc             (rd_pc),
        .read_req_gh             (gh),
        .read_resp_redirect_lane (rd_lane),
        .read_resp_taken         (rd_taken),
        .update_valid            (update_valid),
        .update                  (update)
    );

endmodule

`default_nettype wire

// ==== hdl/bram_2rport_1wport.sv ====
// block RAM with two registered read ports and one byte-enabled write port
// reads see the contents before a write on the same edge

`timescale 1ns/1ps
`default_nettype none

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 16,
    parameter int OUTER_WIDTH = 256
) (
    input  logic                           CLK,
    input  logic                           nRST,

    input  logic                           port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,

    input  logic                           port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,

    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // byte-enabled write
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int b = 0; b < INNER_WIDTH/8; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered reads, output holds while ren is low
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            if (port0_ren) port0_rdata <= mem[port0_rindex];
            if (port1_ren) port1_rdata <= mem[port1_rindex];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ghr.sv ====
// global history register
// shifts each resolved branch outcome into the LSB

`timescale 1ns/1ps
`default_nettype none

module ghr (
    input  logic        CLK,
    input  logic        nRST,

    input  logic        update_valid,
    input  logic        update_taken,

    output bp_pkg::gh_t gh
);

    localparam int GH_BITS = $bits(bp_pkg::gh_t);

    // oldest outcome falls off the MSB
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            gh <= '0;
        end else if (update_valid) begin
            gh <= {gh[GH_BITS-2:0], update_taken};
        end
    end

    // ----------------------------------------------------------
    // checks

    // an unknown outcome would poison every later index hash
    a_taken_known : assert property (
        @(posedge CLK) disable iff (!nRST)
        update_valid |-> !$isunknown(update_taken)
    );

endmodule

`default_nettype wire

// ==== hdl/pht.sv ====
// gshare pattern history table
// port 0 serves predictions, port 1 reads sets for the update write-back
// back-to-back updates to one set use the set written the cycle before

`timescale 1ns/1ps
`default_nettype none

`include "bp_macros.svh"

module pht (
    input  logic                CLK,
    input  logic                nRST,
    input  bp_pkg::asid_t       arch_asid,

    input  logic                read_req_valid,
    input  bp_pkg::pc38_u       read_req_pc,
    input  bp_pkg::gh_t         read_req_gh,

    input  bp_pkg::fetch_lane_t read_resp_redirect_lane,
    output logic                read_resp_taken,

    input  logic                update_valid,
    input  bp_pkg::update_t     update
);

    localparam int SET_BYTES = $bits(bp_pkg::pht_set_t) / 8;

    // ----------------------------------------------------------
    // hashes and counter rule

    // fetch index ^ top history bits ^ reversed asid from the msb down
    function automatic bp_pkg::pht_idx_t index_hash(bp_pkg::fetch_idx_t idx,
                                                    bp_pkg::gh_t gh,
                                                    bp_pkg::asid_t asid);
        bp_pkg::pht_idx_t h;
        h = idx ^ gh[`BP_GH_LENGTH-1 -: `BP_LOG_PHT_SETS];
        for (int i = 0; i < `BP_LOG_PHT_SETS; i++) begin
            h[`BP_LOG_PHT_SETS-1-i] = h[`BP_LOG_PHT_SETS-1-i] ^ asid[i];
        end
        return h;
    endfunction

    function automatic bp_pkg::fetch_lane_t lane_hash(bp_pkg::fetch_lane_t lane,
                                                      bp_pkg::gh_t gh);
        return lane ^ gh[`BP_LOG_FETCH_LANES-1:0];
    endfunction

    // {taken, strong}, weak not-taken is the reset value
    function automatic logic [1:0] ctr_next(logic [1:0] ctr, logic taken);
        case ({ctr, taken})
            3'b000, 3'b010, 3'b100: return 2'b01;
            3'b110:                 return 2'b10;
            3'b011:                 return 2'b00;
            default:                return 2'b11;
        endcase
    endfunction

    // ----------------------------------------------------------
    // prediction read

    bp_pkg::pht_idx_t    p0_idx;
    bp_pkg::pht_set_t    p0_set;
    bp_pkg::gh_t         resp_gh;
    bp_pkg::fetch_lane_t resp_lane;

    assign p0_idx = index_hash(read_req_pc.fields.fetch_idx, read_req_gh, arch_asid);

    // history kept with the RAM output so both hold together
    always_ff @(posedge CLK) begin
        if (read_req_valid) resp_gh <= read_req_gh;
    end

    assign resp_lane       = lane_hash(read_resp_redirect_lane, resp_gh);
    assign read_resp_taken = p0_set[resp_lane][1];

    // ----------------------------------------------------------
    // update read, then write-back one cycle later

    bp_pkg::pht_idx_t    p1_idx;
    bp_pkg::pht_set_t    p1_set;
    logic                w_valid;
    logic                w_fwd;
    bp_pkg::pht_idx_t    w_idx;
    bp_pkg::fetch_lane_t w_lane;
    logic                w_taken;
    bp_pkg::pht_set_t    fwd_set;
    bp_pkg::pht_set_t    old_set;
    bp_pkg::pht_set_t    w_set;
    logic [SET_BYTES-1:0] w_byten;

    assign p1_idx = index_hash(update.pc.fields.fetch_idx, update.gh, arch_asid);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            w_valid <= 1'b0;
            w_fwd   <= 1'b0;
        end else begin
            w_valid <= update_valid;
            // RAM output misses the write landing on this same edge
            w_fwd   <= update_valid & w_valid & (p1_idx == w_idx);
        end
    end

    always_ff @(posedge CLK) begin
        w_idx   <= p1_idx;
        w_lane  <= lane_hash(update.pc.fields.lane, update.gh);
        w_taken <= update.taken;
        fwd_set <= w_set;
    end

    always_comb begin
        old_set         = w_fwd ? fwd_set : p1_set;
        w_set           = old_set;
        w_set[w_lane]   = ctr_next(old_set[w_lane], w_taken);
    end

    assign w_byten = {SET_BYTES{w_valid}};

    bram_2rport_1wport #(
        .INNER_WIDTH($bits(bp_pkg::pht_set_t)),
        .OUTER_WIDTH(1 << `BP_LOG_PHT_SETS)
    ) pht_bram (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (read_req_valid),
        .port0_rindex (p0_idx),
        .port0_rdata  (p0_set),
        .port1_ren    (update_valid),
        .port1_rindex (p1_idx),
        .port1_rdata  (p1_set),
        .wen_byte     (w_byten),
        .windex       (w_idx),
        .wdata        (w_set)
    );

    // write index comes from the update one cycle earlier
    a_windex_known : assert property (
        @(posedge CLK) disable iff (!nRST)
        (|w_byten) |-> !$isunknown(w_idx)
    );

endmodule

`default_nettype wire
